// ==== cpu_testdata.txt ====
// Words 0-3f: program, 40-47: initial data words 0-7, 48: retire count, 49: store count
// From 4a: expected stores, one pair per line as address then write data
4021 4042 4063 0248 6088 042b 60a9 262c
224e 60ca 60eb 2271 610c 4128 612d 9282
602e 604e 8243 2675 614e a018 602f 604f
0077 616f a01a 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
@40
0000 0007 0003 fffb 0000 0000 0000 0000
@48
0016 0008
@4a
0008 000a
0009 fffc
000a 0001
000b 0000
000c ffdd
000d 000a
000e 0019
000f 0005

// ==== cpu.f ====
cpu_pkg.sv
cpu_ctrl_if.sv
cpu_regfile.sv
cpu_seq_mult.sv
cpu_control.sv
cpu_datapath.sv
cpu_top.sv
tb_cpu.sv

// ==== Makefile ====
# Verilator build for the multicycle processor testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= cpu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_cpu.sv ====
// Testbench for the multicycle processor
// Memory models with random latency, ISA reference PC, store and retire checks
`timescale 1ns/100ps

module tb_cpu;
    import cpu_pkg::*;

    // Test data layout
    localparam int DATA_BASE  = 64;
    localparam int RETIRE_IDX = 72;
    localparam int NSTORE_IDX = 73;
    localparam int STORE_BASE = 74;

    logic              clk;
    logic              rst_n;
    logic              imem_req;
    logic [WORD_W-1:0] imem_addr;
    logic              imem_valid;
    logic [WORD_W-1:0] imem_data;
    logic              dmem_req;
    logic              dmem_we;
    logic [WORD_W-1:0] dmem_addr;
    logic [WORD_W-1:0] dmem_wdata;
    logic              dmem_valid;
    logic [WORD_W-1:0] dmem_rdata;
    logic              io_stall;

    logic [15:0] tdata [0:105];
    logic [15:0] imem [0:255];
    logic [15:0] dmem [0:255];
    word_t       regs [0:15];
    logic [15:0] model_pc;
    logic [15:0] cur_instr;
    logic [15:0] retire_cnt;
    logic [15:0] store_cnt;
    logic [31:0] rng;
    logic        imem_pend;
    logic        dmem_pend;
    logic [2:0]  imem_wait;
    logic [2:0]  dmem_wait;
    logic [15:0] imem_addr_q;
    logic [15:0] dmem_addr_q;
    logic        stall_low_q;
    logic        fetch_seen;
    logic        program_done;
    int          cycle_cnt;
    int          limit;

    cpu_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .o_imem_req   (imem_req),
        .o_imem_addr  (imem_addr),
        .i_imem_valid (imem_valid),
        .i_imem_data  (imem_data),
        .o_dmem_req   (dmem_req),
        .o_dmem_we    (dmem_we),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_wdata (dmem_wdata),
        .i_dmem_valid (dmem_valid),
        .i_dmem_rdata (dmem_rdata),
        .o_io_stall   (io_stall)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ========================================================================
    // Helpers
    // ========================================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_on_failure();
        $display("Errors found");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        stop_on_failure();
    endtask

    task automatic check_equal(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected)
        begin
            $display("FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual,
                     expected);
            stop_on_failure();
        end
    endtask

    // Reference execution of the instruction that just retired
    task automatic execute_retired();
        logic [2:0]  op;
        logic [3:0]  rs;
        logic [3:0]  rt;
        logic [3:0]  rd;
        word_t       a;
        word_t       b;
        word_t       imm;
        word_t       ld_addr;
        logic [15:0] next_pc;
        op      = cur_instr[15:13];
        rs      = cur_instr[12:9];
        rt      = cur_instr[8:5];
        rd      = cur_instr[4:1];
        a       = regs[rs];
        b       = regs[rt];
        imm     = {{11{cur_instr[4]}}, cur_instr[4:0]};
        ld_addr = a + imm;
        next_pc = model_pc + 16'd1;
        case (op)
            OP_RTYPE:   regs[rd] = cur_instr[0] ? a - b : a + b;
            OP_SLT_MUL: regs[rd] = cur_instr[0] ? a * b : ((a < b) ? word_t'(1) : word_t'(0));
            OP_LW:      regs[rt] = dmem[ld_addr[7:0]];
            OP_BEQ:
            begin
                if (a == b)
                begin
                    next_pc = model_pc + 16'd1 + imm;
                end
            end
            OP_J:       next_pc = {3'b000, cur_instr[12:0]};
            default:    ;
        endcase
        model_pc = next_pc;
    endtask

    task automatic handle_fetch();
        if (imem_pend || dmem_pend)
        begin
            abort_run("Fetch request issued while another request is outstanding");
        end
        check_equal("o_imem_addr", imem_addr, model_pc);
        fetch_seen = 1'b1;
        cur_instr  = imem[model_pc[7:0]];
        // A jump to its own address ends the program
        if ((cur_instr[15:13] == OP_J) && (cur_instr[12:0] == model_pc[12:0]))
        begin
            program_done = 1'b1;
        end
        rng         = xorshift32(rng);
        imem_wait   = {1'b0, rng[1:0]} + 3'd1;
        imem_addr_q = imem_addr;
        imem_pend   = 1'b1;
    endtask

    task automatic handle_dmem_req();
        logic [6:0] pair_idx;
        word_t      ld_addr;
        if (imem_pend || dmem_pend)
        begin
            abort_run("Data request issued while another request is outstanding");
        end
        check_equal("o_dmem_we", 16'(dmem_we), 16'(cur_instr[15:13] == OP_SW));
        if (dmem_we)
        begin
            if (store_cnt >= tdata[NSTORE_IDX])
            begin
                abort_run("More stores than the expected store list holds");
            end
            pair_idx = 7'(STORE_BASE) + 7'(store_cnt << 1);
            check_equal("o_dmem_addr", dmem_addr, tdata[pair_idx]);
            check_equal("o_dmem_wdata", dmem_wdata, tdata[pair_idx + 7'd1]);
            dmem[dmem_addr[7:0]] = dmem_wdata;
            store_cnt = store_cnt + 16'd1;
        end
        else
        begin
            // Load address from the reference registers
            ld_addr = regs[cur_instr[12:9]] + word_t'({{11{cur_instr[4]}}, cur_instr[4:0]});
            check_equal("o_dmem_addr", dmem_addr, ld_addr);
        end
        rng         = xorshift32(rng);
        dmem_wait   = {1'b0, rng[1:0]} + 3'd1;
        dmem_addr_q = dmem_addr;
        dmem_pend   = 1'b1;
    endtask

    // ========================================================================
    // Memory models and monitors, all on the falling edge
    // ========================================================================
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            imem_valid = 1'b0;
            dmem_valid = 1'b0;
            if (imem_pend)
            begin
                if (imem_wait == 3'd1)
                begin
                    imem_valid = 1'b1;
                    imem_data  = imem[imem_addr_q[7:0]];
                    imem_pend  = 1'b0;
                end
                else
                begin
                    imem_wait = imem_wait - 3'd1;
                end
            end
            if (dmem_pend)
            begin
                if (dmem_wait == 3'd1)
                begin
                    dmem_valid = 1'b1;
                    dmem_rdata = dmem[dmem_addr_q[7:0]];
                    dmem_pend  = 1'b0;
                end
                else
                begin
                    dmem_wait = dmem_wait - 3'd1;
                end
            end
            if (!fetch_seen)
            begin
                check_equal("o_io_stall", 16'(io_stall), 16'd1);
            end
            // Retire pulse, exactly one cycle wide
            if (!io_stall)
            begin
                check_equal("o_io_stall low in previous cycle", 16'(stall_low_q), 16'd0);
                retire_cnt = retire_cnt + 16'd1;
                execute_retired();
            end
            stall_low_q = !io_stall;
            if (dmem_req)
            begin
                handle_dmem_req();
            end
            if (imem_req)
            begin
                handle_fetch();
            end
        end
    end

    // ========================================================================
    // Setup, reset and run control
    // ========================================================================
    initial
    begin
        rst_n        = 1'b0;
        imem_valid   = 1'b0;
        imem_data    = '0;
        dmem_valid   = 1'b0;
        dmem_rdata   = '0;
        rng          = 32'h325f_f72f;
        model_pc     = '0;
        cur_instr    = '0;
        retire_cnt   = '0;
        store_cnt    = '0;
        imem_pend    = 1'b0;
        dmem_pend    = 1'b0;
        imem_wait    = '0;
        dmem_wait    = '0;
        imem_addr_q  = '0;
        dmem_addr_q  = '0;
        stall_low_q  = 1'b0;
        fetch_seen   = 1'b0;
        program_done = 1'b0;
        cycle_cnt    = 0;
        $readmemh("cpu_testdata.txt", tdata);
        if ($isunknown(tdata[RETIRE_IDX]) || (tdata[RETIRE_IDX] == 16'h0000))
        begin
            abort_run("Test data file cpu_testdata.txt could not be read");
        end
        for (int i = 0; i < 256; i++)
        begin
            imem[i] = (i < DATA_BASE) ? tdata[i] : 16'h0000;
            dmem[i] = 16'h0000;
        end
        for (int i = 0; i < 8; i++)
        begin
            dmem[i] = tdata[DATA_BASE + i];
        end
        for (int i = 0; i < 16; i++)
        begin
            regs[i] = '0;
        end
        limit = int'(tdata[RETIRE_IDX]) * 40;

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_equal("o_io_stall", 16'(io_stall), 16'd1);
        check_equal("o_imem_req", 16'(imem_req), 16'd0);
        check_equal("o_dmem_req", 16'(dmem_req), 16'd0);
        rst_n = 1'b1;

        while (!program_done)
        begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
            if (cycle_cnt > limit)
            begin
                abort_run("Timeout: the program did not reach its final jump in time");
            end
        end

        check_equal("retire count", retire_cnt, tdata[RETIRE_IDX]);
        check_equal("store count", store_cnt, tdata[NSTORE_IDX]);
        $display("No errors");
        $finish;
    end

endmodule

// ==== cpu_top.sv ====
// Top level of the multicycle processor
// Joins the FSM and the datapath behind plain memory ports
`timescale 1ns/100ps

module cpu_top (
    input  logic                       clk,
    input  logic                       rst_n,
    // Instruction memory
    output logic                       o_imem_req,
    output logic [cpu_pkg::WORD_W-1:0] o_imem_addr,
    input  logic                       i_imem_valid,
    input  logic [cpu_pkg::WORD_W-1:0] i_imem_data,
    // Data memory
    output logic                       o_dmem_req,
    output logic                       o_dmem_we,
    output logic [cpu_pkg::WORD_W-1:0] o_dmem_addr,
    output logic [cpu_pkg::WORD_W-1:0] o_dmem_wdata,
    input  logic                       i_dmem_valid,
    input  logic [cpu_pkg::WORD_W-1:0] i_dmem_rdata,
    // Low for one cycle per retired instruction
    output logic                       o_io_stall
);

    cpu_ctrl_if u_ctrl_if ();

    cpu_control u_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (u_ctrl_if.ctrl),
        .i_imem_valid (i_imem_valid),
        .i_dmem_valid (i_dmem_valid),
        .o_imem_req   (o_imem_req),
        .o_dmem_req   (o_dmem_req),
        .o_dmem_we    (o_dmem_we),
        .o_io_stall   (o_io_stall)
    );

    cpu_datapath u_datapath (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (u_ctrl_if.dp),
        .i_imem_data  (i_imem_data),
        .i_dmem_rdata (i_dmem_rdata),
        .o_imem_addr  (o_imem_addr),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata)
    );

endmodule

// ==== cpu_datapath.sv ====
// Processor datapath with PC, instruction register, operands and ALU
// Holds the memory addresses and owns the register file and multiplier
`timescale 1ns/100ps

module cpu_datapath (
    input  logic                       clk,
    input  logic                       rst_n,
    cpu_ctrl_if.dp                     ctrl,
    input  logic [cpu_pkg::WORD_W-1:0] i_imem_data,
    input  logic [cpu_pkg::WORD_W-1:0] i_dmem_rdata,
    output logic [cpu_pkg::WORD_W-1:0] o_imem_addr,
    output logic [cpu_pkg::WORD_W-1:0] o_dmem_addr,
    output logic [cpu_pkg::WORD_W-1:0] o_dmem_wdata
);
    import cpu_pkg::*;

    logic [WORD_W-1:0] pc_q;
    logic [WORD_W-1:0] ir_q;
    word_t             op_a_q;
    word_t             op_b_q;
    word_t             alu_q;
    word_t             mem_q;
    word_t             alu_res;
    word_t             imm_ext;
    word_t             rs_data;
    word_t             rt_data;
    word_t             mult_prod;
    opcode_e           opcode;
    reg_idx_t          rs;
    reg_idx_t          rt;
    reg_idx_t          rd;
    logic              mult_ex_d1;
    logic              mult_start;

    // Instruction fields
    assign opcode  = opcode_e'(ir_q[WORD_W-1 -: $bits(opcode_e)]);
    assign rs      = ir_q[12:9];
    assign rt      = ir_q[8:5];
    assign rd      = ir_q[4:1];
    assign imm_ext = {{(WORD_W-IMM_W){ir_q[IMM_W-1]}}, ir_q[IMM_W-1:0]};

    assign ctrl.opcode = opcode;
    assign ctrl.func   = ir_q[0];

    // =========================================================================
    // PC and instruction register
    // =========================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc_q <= '0;
        end
        else if ((ctrl.state == ID) && (opcode == OP_J))
        begin
            pc_q <= {{(WORD_W-JADDR_W){1'b0}}, ir_q[JADDR_W-1:0]};
        end
        else if ((ctrl.state == ID) || ((ctrl.state == BEQ_EX) && (op_a_q == op_b_q)))
        begin
            pc_q <= alu_res;
        end
    end

    // Payload registers
    always_ff @(posedge clk)
    begin
        if ((ctrl.state == IF_WAIT) && ctrl.imem_valid)
        begin
            ir_q <= i_imem_data;
        end
        if (ctrl.state == ID)
        begin
            op_a_q <= rs_data;
            op_b_q <= rt_data;
        end
        if ((ctrl.state == LW_WAIT) && ctrl.dmem_valid)
        begin
            mem_q <= i_dmem_rdata;
        end
    end

    // =========================================================================
    // ALU
    // =========================================================================
    always_comb
    begin
        case (ctrl.state)
            ID:           alu_res = $signed(pc_q) + word_t'(1);
            ADD_EX:       alu_res = op_a_q + op_b_q;
            SUB_EX:       alu_res = op_a_q - op_b_q;
            SLT_EX:       alu_res = (op_a_q < op_b_q) ? word_t'(1) : word_t'(0);
            LW_EX, SW_EX: alu_res = op_a_q + imm_ext;
            // PC already points past the branch
            BEQ_EX:       alu_res = $signed(pc_q) + imm_ext;
            default:      alu_res = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if ((ctrl.state == MULT_EX) && ctrl.mult_done)
        begin
            alu_q <= mult_prod;
        end
        else if ((ctrl.state == ADD_EX) || (ctrl.state == SUB_EX) || (ctrl.state == SLT_EX)
              || (ctrl.state == LW_EX) || (ctrl.state == SW_EX))
        begin
            alu_q <= alu_res;
        end
    end

    // Start pulse on the first MULT_EX cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mult_ex_d1 <= 1'b0;
        end
        else
        begin
            mult_ex_d1 <= (ctrl.state == MULT_EX);
        end
    end

    assign mult_start = (ctrl.state == MULT_EX) && !mult_ex_d1;

    cpu_seq_mult u_mult (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_start   (mult_start),
        .i_a       (op_a_q),
        .i_b       (op_b_q),
        .o_done    (ctrl.mult_done),
        .o_product (mult_prod)
    );

    // R-type writes rd, loads write rt
    cpu_regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_rs_idx  (rs),
        .i_rt_idx  (rt),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_we      ((ctrl.state == R_WB) || (ctrl.state == MEM_WB)),
        .i_wr_idx  ((ctrl.state == R_WB) ? rd : rt),
        .i_wr_data ((ctrl.state == R_WB) ? alu_q : mem_q)
    );

    assign o_imem_addr  = pc_q;
    assign o_dmem_addr  = alu_q;
    assign o_dmem_wdata = op_b_q;

endmodule

// ==== cpu_control.sv ====
// Main FSM of the processor
// Sequences each instruction and drives the memory strobes and the retire flag
`timescale 1ns/100ps

module cpu_control (
    input  logic       clk,
    input  logic       rst_n,
    cpu_ctrl_if.ctrl   ctrl,
    input  logic       i_imem_valid,
    input  logic       i_dmem_valid,
    output logic       o_imem_req,
    output logic       o_dmem_req,
    output logic       o_dmem_we,
    output logic       o_io_stall
);
    import cpu_pkg::*;

    cpu_state_e state_q;
    cpu_state_e state_nxt;
    logic       retire;

    assign ctrl.state      = state_q;
    assign ctrl.imem_valid = i_imem_valid;
    assign ctrl.dmem_valid = i_dmem_valid;

    // =========================================================================
    // State register and next state
    // =========================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= IF_REQ;
        end
        else
        begin
            state_q <= state_nxt;
        end
    end

    always_comb
    begin
        state_nxt = state_q;
        case (state_q)
            IF_REQ:  state_nxt = IF_WAIT;
            IF_WAIT: state_nxt = i_imem_valid ? ID : IF_WAIT;
            ID:
            begin
                case (ctrl.opcode)
                    OP_RTYPE:   state_nxt = ctrl.func ? SUB_EX : ADD_EX;
                    OP_SLT_MUL: state_nxt = ctrl.func ? MULT_EX : SLT_EX;
                    OP_LW:      state_nxt = LW_EX;
                    OP_SW:      state_nxt = SW_EX;
                    OP_BEQ:     state_nxt = BEQ_EX;
                    // J finishes here, unused opcodes fall through as no-ops
                    default:    state_nxt = IF_REQ;
                endcase
            end
            ADD_EX, SUB_EX, SLT_EX: state_nxt = R_WB;
            MULT_EX: state_nxt = ctrl.mult_done ? R_WB : MULT_EX;
            LW_EX:   state_nxt = LW_WAIT;
            SW_EX:   state_nxt = SW_WAIT;
            LW_WAIT: state_nxt = i_dmem_valid ? MEM_WB : LW_WAIT;
            SW_WAIT: state_nxt = i_dmem_valid ? IF_REQ : SW_WAIT;
            default: state_nxt = IF_REQ;
        endcase
    end

    // =========================================================================
    // Strobes and retire flag
    // =========================================================================
    assign retire = (state_q == R_WB) || (state_q == MEM_WB) || (state_q == BEQ_EX)
                 || ((state_q == ID) && (ctrl.opcode == OP_J))
                 || ((state_q == SW_WAIT) && i_dmem_valid);

    // Requests fire in the cycle after the issuing state
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_imem_req <= 1'b0;
            o_dmem_req <= 1'b0;
            o_dmem_we  <= 1'b0;
            o_io_stall <= 1'b1;
        end
        else
        begin
            o_imem_req <= (state_q == IF_REQ);
            o_dmem_req <= (state_q == LW_EX) || (state_q == SW_EX);
            o_dmem_we  <= (state_q == SW_EX);
            o_io_stall <= !retire;
        end
    end

endmodule

// ==== cpu_seq_mult.sv ====
// Sequential shift-add multiplier, one multiplier bit per cycle
// Returns the low word of the product
`timescale 1ns/100ps

module cpu_seq_mult (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           i_start,
    input  cpu_pkg::word_t i_a,
    input  cpu_pkg::word_t i_b,
    output logic           o_done,
    output cpu_pkg::word_t o_product
);
    import cpu_pkg::*;

    word_t                     acc_q;
    word_t                     mcand_q;
    logic [WORD_W-1:0]         mplier_q;
    logic [$clog2(WORD_W)-1:0] cnt_q;
    logic                      busy_q;

    // First partial product is taken with the start pulse
    always_ff @(posedge clk)
    begin
        if (i_start)
        begin
            acc_q    <= i_b[0] ? i_a : '0;
            mcand_q  <= i_a <<< 1;
            mplier_q <= i_b >> 1;
        end
        else if (busy_q)
        begin
            if (mplier_q[0])
            begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q <<< 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt_q  <= '0;
            busy_q <= 1'b0;
            o_done <= 1'b0;
        end
        else
        begin
            o_done <= busy_q && (cnt_q == '1);
            if (i_start)
            begin
                cnt_q  <= 1;
                busy_q <= 1'b1;
            end
            else if (busy_q)
            begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == '1)
                begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    assign o_product = acc_q;

endmodule

// ==== cpu_regfile.sv ====
// Sixteen-entry register file, two asynchronous reads and one write
`timescale 1ns/100ps

module cpu_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t i_rs_idx,
    input  cpu_pkg::reg_idx_t i_rt_idx,
    output cpu_pkg::word_t    o_rs_data,
    output cpu_pkg::word_t    o_rt_data,
    input  logic              i_we,
    input  cpu_pkg::reg_idx_t i_wr_idx,
    input  cpu_pkg::word_t    i_wr_data
);
    import cpu_pkg::*;

    word_t regs [2**REG_AW];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 2**REG_AW; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_we)
        begin
            regs[i_wr_idx] <= i_wr_data;
        end
    end

    assign o_rs_data = regs[i_rs_idx];
    assign o_rt_data = regs[i_rt_idx];

endmodule

// ==== cpu_ctrl_if.sv ====
// Control interface between the main FSM and the datapath
`timescale 1ns/100ps

interface cpu_ctrl_if;
    import cpu_pkg::*;

    cpu_state_e state;
    opcode_e    opcode;
    logic       func;
    logic       mult_done;
    // Memory responses forwarded by the FSM
    logic       imem_valid;
    logic       dmem_valid;

    modport ctrl (
        output state, imem_valid, dmem_valid,
        input  opcode, func, mult_done
    );

    modport dp (
        input  state, imem_valid, dmem_valid,
        output opcode, func, mult_done
    );

endinterface

// ==== cpu_pkg.sv ====
// Shared definitions for the 16-bit multicycle processor
// Field widths, opcode and state encodings, word and register index types
package cpu_pkg;

    // =========================================================================
    // Widths
    // =========================================================================
    localparam int WORD_W  = 16;
    localparam int REG_AW  = 4;
    localparam int IMM_W   = 5;
    localparam int JADDR_W = 13;

    typedef logic signed [WORD_W-1:0] word_t;
    typedef logic [REG_AW-1:0]        reg_idx_t;

    // =========================================================================
    // Encodings
    // =========================================================================
    // Bits 15:13 of the instruction word
    typedef enum logic [2:0] {
        OP_RTYPE   = 3'b000,
        OP_SLT_MUL = 3'b001,
        OP_LW      = 3'b010,
        OP_SW      = 3'b011,
        OP_BEQ     = 3'b100,
        OP_J       = 3'b101
    } opcode_e;

    // Main FSM states
    typedef enum logic [3:0] {
        IF_REQ,
        IF_WAIT,
        ID,
        ADD_EX,
        SUB_EX,
        SLT_EX,
        MULT_EX,
        R_WB,
        LW_EX,
        SW_EX,
        BEQ_EX,
        LW_WAIT,
        SW_WAIT,
        MEM_WB
    } cpu_state_e;

endpackage
